//--- accel_pkg.sv
package accel_pkg;

  // Datapath widths
  localparam int data_w    = 64;
  localparam int addr_w    = 40;
  localparam int reg_w     = 5;
  localparam int funct_w   = 7;
  localparam int cmd_w     = 160;
  localparam int mem_cmd_w = 5;

  // Field positions inside the packed command word
  localparam int cmd_funct_lsb = 0;
  localparam int cmd_rd_lsb    = 20;
  localparam int cmd_rs1_lsb   = 32;
  localparam int cmd_rs2_lsb   = 96;

  // Function codes
  localparam logic [funct_w-1:0] funct_store = 7'd0;
  localparam logic [funct_w-1:0] funct_load  = 7'd1;
  localparam logic [funct_w-1:0] funct_add   = 7'd2;

  // Memory command codes, 64-bit accesses only
  localparam logic [mem_cmd_w-1:0] mem_cmd_load  = 5'd0;
  localparam logic [mem_cmd_w-1:0] mem_cmd_store = 5'd1;

  // Controller states
  localparam int state_w = 3;

  localparam logic [state_w-1:0] st_idle       = 3'd0;
  localparam logic [state_w-1:0] st_store      = 3'd1;
  localparam logic [state_w-1:0] st_store_wait = 3'd2;
  localparam logic [state_w-1:0] st_load       = 3'd3;
  localparam logic [state_w-1:0] st_load_wait  = 3'd4;
  // Single cycle for the adder result to settle into the response register
  localparam logic [state_w-1:0] st_add        = 3'd5;
  localparam logic [state_w-1:0] st_done       = 3'd6;

endpackage

//--- accel_ctrl.sv
`timescale 1ns/10ps

module accel_ctrl (
  input  logic                           dpath_clk,
  input  logic                           ctrl_rst,

  // Core command side
  input  logic                           cmd_vld,
  input  logic [accel_pkg::funct_w-1:0]  cmd_funct,
  output logic                           cmd_rdy,
  output logic                           cmd_go,

  // Memory side
  input  logic                           mem_req_rdy,
  input  logic                           mem_resp_vld,
  output logic                           mem_req_vld,
  output logic [accel_pkg::mem_cmd_w-1:0] mem_req_cmd,

  // Response side
  input  logic                           resp_rdy,
  output logic                           resp_capture,
  output logic                           resp_sel_mem,
  output logic                           resp_sel_store,
  output logic                           resp_vld
);

  logic [accel_pkg::state_w-1:0] state;
  logic [accel_pkg::state_w-1:0] state_next;
  logic                          mem_wait;

  always_ff @(posedge dpath_clk) begin
    if (ctrl_rst) begin
      state <= accel_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  // Handshake strobes
  assign cmd_go   = cmd_vld && cmd_rdy;
  assign mem_wait = (state == accel_pkg::st_store_wait) ||
                    (state == accel_pkg::st_load_wait);

  // Sum is ready in st_add, memory data is ready on the response pulse
  assign resp_capture = (state == accel_pkg::st_add) || (mem_wait && mem_resp_vld);

  always_comb begin
    state_next = state;
    case (state)
      accel_pkg::st_idle: begin
        if (cmd_go) begin
          case (cmd_funct)
            accel_pkg::funct_store: state_next = accel_pkg::st_store;
            accel_pkg::funct_load:  state_next = accel_pkg::st_load;
            accel_pkg::funct_add:   state_next = accel_pkg::st_add;
            // Unknown code is dropped
            default:                state_next = accel_pkg::st_idle;
          endcase
        end
      end
      accel_pkg::st_store: begin
        if (mem_req_rdy) begin
          state_next = accel_pkg::st_store_wait;
        end
      end
      accel_pkg::st_store_wait: begin
        if (mem_resp_vld) begin
          state_next = accel_pkg::st_done;
        end
      end
      accel_pkg::st_load: begin
        if (mem_req_rdy) begin
          state_next = accel_pkg::st_load_wait;
        end
      end
      accel_pkg::st_load_wait: begin
        if (mem_resp_vld) begin
          state_next = accel_pkg::st_done;
        end
      end
      accel_pkg::st_add: begin
        state_next = accel_pkg::st_done;
      end
      accel_pkg::st_done: begin
        if (resp_rdy) begin
          state_next = accel_pkg::st_idle;
        end
      end
      default: begin
        state_next = accel_pkg::st_idle;
      end
    endcase
  end

  // Moore outputs
  always_comb begin
    cmd_rdy        = 1'b0;
    mem_req_vld    = 1'b0;
    mem_req_cmd    = accel_pkg::mem_cmd_load;
    resp_sel_mem   = 1'b0;
    resp_sel_store = 1'b0;
    resp_vld       = 1'b0;
    case (state)
      accel_pkg::st_idle: begin
        cmd_rdy = 1'b1;
      end
      accel_pkg::st_store: begin
        mem_req_vld    = 1'b1;
        mem_req_cmd    = accel_pkg::mem_cmd_store;
        resp_sel_mem   = 1'b1;
        resp_sel_store = 1'b1;
      end
      accel_pkg::st_store_wait: begin
        resp_sel_mem   = 1'b1;
        resp_sel_store = 1'b1;
      end
      accel_pkg::st_load: begin
        mem_req_vld  = 1'b1;
        mem_req_cmd  = accel_pkg::mem_cmd_load;
        resp_sel_mem = 1'b1;
      end
      accel_pkg::st_load_wait: begin
        resp_sel_mem = 1'b1;
      end
      accel_pkg::st_done: begin
        resp_vld = 1'b1;
      end
      default: begin
        resp_sel_mem = 1'b0;
      end
    endcase
  end

endmodule

//--- accel_dpath.sv
`timescale 1ns/10ps

module accel_dpath (
  input  logic                          dpath_clk,

  // Command capture
  input  logic                          cmd_go,
  input  logic [accel_pkg::reg_w-1:0]   cmd_rd,
  input  logic [accel_pkg::data_w-1:0]  rs1_data,
  input  logic [accel_pkg::data_w-1:0]  rs2_data,

  // Controls from the FSM
  input  logic                          resp_capture,
  input  logic                          resp_sel_mem,
  input  logic                          resp_sel_store,

  // Memory data
  input  logic [accel_pkg::data_w-1:0]  mem_resp_data,
  input  logic [accel_pkg::data_w-1:0]  mem_resp_store_data,
  output logic [accel_pkg::addr_w-1:0]  mem_req_addr,
  output logic [accel_pkg::data_w-1:0]  mem_req_data,

  // Response register
  output logic [accel_pkg::reg_w-1:0]   resp_rd,
  output logic [accel_pkg::data_w-1:0]  resp_data
);

  logic [accel_pkg::reg_w-1:0]  rd_q;
  logic [accel_pkg::data_w-1:0] rs1_q;
  logic [accel_pkg::data_w-1:0] rs2_q;
  logic [accel_pkg::data_w-1:0] sum;
  logic [accel_pkg::data_w-1:0] result;

  // Operands held for the whole command
  always_ff @(posedge dpath_clk) begin
    if (cmd_go) begin
      rd_q  <= cmd_rd;
      rs1_q <= rs1_data;
      rs2_q <= rs2_data;
    end
  end

  assign mem_req_data = rs1_q;
  assign mem_req_addr = rs2_q[accel_pkg::addr_w-1:0];

  // Wraps on overflow
  assign sum = rs1_q + rs2_q;

  always_comb begin
    if (!resp_sel_mem) begin
      result = sum;
    end else if (resp_sel_store) begin
      result = mem_resp_store_data;
    end else begin
      result = mem_resp_data;
    end
  end

  always_ff @(posedge dpath_clk) begin
    if (resp_capture) begin
      resp_rd   <= rd_q;
      resp_data <= result;
    end
  end

endmodule

//--- accel_top.sv
`timescale 1ns/10ps

module accel_top (
  input  logic                            dpath_clk,
  input  logic                            ctrl_rst,

  // Core command channel
  input  logic [accel_pkg::cmd_w-1:0]     cmd,
  input  logic                            cmd_vld,
  output logic                            cmd_rdy,

  // Core response channel
  output logic [accel_pkg::reg_w-1:0]     resp_rd,
  output logic [accel_pkg::data_w-1:0]    resp_data,
  output logic                            resp_vld,
  input  logic                            resp_rdy,

  // Memory request channel
  output logic                            mem_req_vld,
  input  logic                            mem_req_rdy,
  output logic [accel_pkg::mem_cmd_w-1:0] mem_req_cmd,
  output logic [accel_pkg::addr_w-1:0]    mem_req_addr,
  output logic [accel_pkg::data_w-1:0]    mem_req_data,

  // Memory response channel
  input  logic                            mem_resp_vld,
  input  logic [accel_pkg::data_w-1:0]    mem_resp_data,
  input  logic [accel_pkg::data_w-1:0]    mem_resp_store_data
);

  logic [accel_pkg::funct_w-1:0] cmd_funct;
  logic [accel_pkg::reg_w-1:0]   cmd_rd;
  logic [accel_pkg::data_w-1:0]  rs1_data;
  logic [accel_pkg::data_w-1:0]  rs2_data;

  logic cmd_go;
  logic resp_capture;
  logic resp_sel_mem;
  logic resp_sel_store;

  // Unpack the command word from the core
  assign cmd_funct = cmd[accel_pkg::cmd_funct_lsb +: accel_pkg::funct_w];
  assign cmd_rd    = cmd[accel_pkg::cmd_rd_lsb +: accel_pkg::reg_w];
  assign rs1_data  = cmd[accel_pkg::cmd_rs1_lsb +: accel_pkg::data_w];
  assign rs2_data  = cmd[accel_pkg::cmd_rs2_lsb +: accel_pkg::data_w];

  accel_ctrl u_ctrl (
    .dpath_clk      (dpath_clk),
    .ctrl_rst       (ctrl_rst),
    .cmd_vld        (cmd_vld),
    .cmd_funct      (cmd_funct),
    .cmd_rdy        (cmd_rdy),
    .cmd_go         (cmd_go),
    .mem_req_rdy    (mem_req_rdy),
    .mem_resp_vld   (mem_resp_vld),
    .mem_req_vld    (mem_req_vld),
    .mem_req_cmd    (mem_req_cmd),
    .resp_rdy       (resp_rdy),
    .resp_capture   (resp_capture),
    .resp_sel_mem   (resp_sel_mem),
    .resp_sel_store (resp_sel_store),
    .resp_vld       (resp_vld)
  );

  accel_dpath u_dpath (
    .dpath_clk           (dpath_clk),
    .cmd_go              (cmd_go),
    .cmd_rd              (cmd_rd),
    .rs1_data            (rs1_data),
    .rs2_data            (rs2_data),
    .resp_capture        (resp_capture),
    .resp_sel_mem        (resp_sel_mem),
    .resp_sel_store      (resp_sel_store),
    .mem_resp_data       (mem_resp_data),
    .mem_resp_store_data (mem_resp_store_data),
    .mem_req_addr        (mem_req_addr),
    .mem_req_data        (mem_req_data),
    .resp_rd             (resp_rd),
    .resp_data           (resp_data)
  );

endmodule

//--- tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model (
  input  logic                            dpath_clk,
  input  logic                            ctrl_rst,
  input  logic                            mem_req_vld,
  output logic                            mem_req_rdy,
  input  logic [accel_pkg::mem_cmd_w-1:0] mem_req_cmd,
  input  logic [accel_pkg::addr_w-1:0]    mem_req_addr,
  input  logic [accel_pkg::data_w-1:0]    mem_req_data,
  output logic                            mem_resp_vld,
  output logic [accel_pkg::data_w-1:0]    mem_resp_data,
  output logic [accel_pkg::data_w-1:0]    mem_resp_store_data
);

  logic [accel_pkg::data_w-1:0] words [logic [accel_pkg::addr_w-1:0]];
  logic                         busy;
  logic                         answer_store;
  logic [accel_pkg::data_w-1:0] answer;
  int                           delay;

  initial begin
    mem_req_rdy         = 1'b0;
    mem_resp_vld        = 1'b0;
    mem_resp_data       = '0;
    mem_resp_store_data = '0;
    busy                = 1'b0;
    answer_store        = 1'b0;
    answer              = '0;
    delay               = 0;
    forever begin
      @(negedge dpath_clk);
      mem_resp_vld = 1'b0;
      if (ctrl_rst) begin
        busy        = 1'b0;
        mem_req_rdy = 1'b0;
      end else if (busy) begin
        mem_req_rdy = 1'b0;
        delay       = delay - 1;
        if (delay == 0) begin
          busy         = 1'b0;
          mem_resp_vld = 1'b1;
          // Unused word is inverted so a wrong select shows up
          if (answer_store) begin
            mem_resp_store_data = answer;
            mem_resp_data       = ~answer;
          end else begin
            mem_resp_store_data = ~answer;
            mem_resp_data       = answer;
          end
        end
      end else begin
        mem_req_rdy = ($urandom % 4) != 0;
        if (mem_req_vld && mem_req_rdy) begin
          // Accepted on the next rising edge
          if (mem_req_cmd == accel_pkg::mem_cmd_store) begin
            words[mem_req_addr] = mem_req_data;
            answer              = mem_req_data;
            answer_store        = 1'b1;
          end else begin
            answer       = words.exists(mem_req_addr) ? words[mem_req_addr] : 64'h0;
            answer_store = 1'b0;
          end
          busy  = 1'b1;
          delay = int'($urandom % 5) + 1;
        end
      end
    end
  end

endmodule

//--- tb_accel_top.sv
`timescale 1ns/10ps

module tb_accel_top;

  localparam int wait_limit = 200;
  localparam int num_random = 300;

  logic                            dpath_clk;
  logic                            ctrl_rst;
  logic [accel_pkg::cmd_w-1:0]     cmd;
  logic                            cmd_vld;
  logic                            cmd_rdy;
  logic [accel_pkg::reg_w-1:0]     resp_rd;
  logic [accel_pkg::data_w-1:0]    resp_data;
  logic                            resp_vld;
  logic                            resp_rdy;
  logic                            mem_req_vld;
  logic                            mem_req_rdy;
  logic [accel_pkg::mem_cmd_w-1:0] mem_req_cmd;
  logic [accel_pkg::addr_w-1:0]    mem_req_addr;
  logic [accel_pkg::data_w-1:0]    mem_req_data;
  logic                            mem_resp_vld;
  logic [accel_pkg::data_w-1:0]    mem_resp_data;
  logic [accel_pkg::data_w-1:0]    mem_resp_store_data;

  // Expected responses as {rd, data}, oldest first
  logic [accel_pkg::reg_w+accel_pkg::data_w-1:0] exp_q[$];
  logic [accel_pkg::data_w-1:0] ref_mem [logic [accel_pkg::addr_w-1:0]];
  logic                            exp_any;
  logic [accel_pkg::reg_w-1:0]     exp_rd;
  logic [accel_pkg::data_w-1:0]    exp_data;
  logic                            resp_taken;
  logic                            exp_mem_on;
  logic [accel_pkg::mem_cmd_w-1:0] exp_mem_cmd;
  logic [accel_pkg::addr_w-1:0]    exp_mem_addr;
  logic [accel_pkg::data_w-1:0]    exp_mem_wdata;
  logic [accel_pkg::addr_w-1:0]    addr_base;
  logic [accel_pkg::data_w-1:0]    seed_word;

  int errors = 0;
  int timeouts;
  int n_sent;
  int n_resp;
  int n_dropped;

  logic [accel_pkg::funct_w-1:0] drv_funct;
  logic                          cmd_take;
  logic                          add_take;
  logic                          bad_take;

  assign drv_funct = cmd[accel_pkg::cmd_funct_lsb +: accel_pkg::funct_w];
  assign cmd_take  = cmd_vld && cmd_rdy;
  assign add_take  = cmd_take && (drv_funct == accel_pkg::funct_add);
  assign bad_take  = cmd_take && (drv_funct != accel_pkg::funct_store) &&
                     (drv_funct != accel_pkg::funct_load) &&
                     (drv_funct != accel_pkg::funct_add);

  initial begin
    dpath_clk = 1'b0;
    forever #2 dpath_clk = ~dpath_clk;
  end

  accel_top dut (
    .dpath_clk           (dpath_clk),
    .ctrl_rst            (ctrl_rst),
    .cmd                 (cmd),
    .cmd_vld             (cmd_vld),
    .cmd_rdy             (cmd_rdy),
    .resp_rd             (resp_rd),
    .resp_data           (resp_data),
    .resp_vld            (resp_vld),
    .resp_rdy            (resp_rdy),
    .mem_req_vld         (mem_req_vld),
    .mem_req_rdy         (mem_req_rdy),
    .mem_req_cmd         (mem_req_cmd),
    .mem_req_addr        (mem_req_addr),
    .mem_req_data        (mem_req_data),
    .mem_resp_vld        (mem_resp_vld),
    .mem_resp_data       (mem_resp_data),
    .mem_resp_store_data (mem_resp_store_data)
  );

  tb_mem_model mem (
    .dpath_clk           (dpath_clk),
    .ctrl_rst            (ctrl_rst),
    .mem_req_vld         (mem_req_vld),
    .mem_req_rdy         (mem_req_rdy),
    .mem_req_cmd         (mem_req_cmd),
    .mem_req_addr        (mem_req_addr),
    .mem_req_data        (mem_req_data),
    .mem_resp_vld        (mem_resp_vld),
    .mem_resp_data       (mem_resp_data),
    .mem_resp_store_data (mem_resp_store_data)
  );

  // Core side of the response channel with random stalls
  initial begin
    resp_rdy   = 1'b0;
    resp_taken = 1'b0;
    exp_any    = 1'b0;
    exp_rd     = '0;
    exp_data   = '0;
    forever begin
      @(negedge dpath_clk);
      if (resp_taken && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
        n_resp++;
      end
      exp_any = exp_q.size() > 0;
      if (exp_any) begin
        {exp_rd, exp_data} = exp_q[0];
      end
      resp_rdy   = !ctrl_rst && (($urandom % 3) != 0);
      resp_taken = resp_vld && resp_rdy;
    end
  end

  reset_state_chk: assert property (@(posedge dpath_clk) disable iff (ctrl_rst)
    $fell(ctrl_rst) |-> cmd_rdy && !resp_vld && !mem_req_vld)
  else begin
    errors++;
    $display("Error at %0t: wrong handshake outputs after reset", $time);
  end

  add_early_chk: assert property (@(posedge dpath_clk) disable iff (ctrl_rst)
    $past(add_take) |-> !resp_vld)
  else begin
    errors++;
    $display("Error at %0t: add response one cycle after accept", $time);
  end

  add_latency_chk: assert property (@(posedge dpath_clk) disable iff (ctrl_rst)
    $past(add_take, 2) |-> resp_vld)
  else begin
    errors++;
    $display("Error at %0t: add response missing two cycles after accept", $time);
  end

  resp_extra_chk: assert property (@(posedge dpath_clk) disable iff (ctrl_rst)
    resp_vld |-> exp_any)
  else begin
    errors++;
    $display("Error at %0t: response rd=%0d with none expected", $time, resp_rd);
  end

  resp_value_chk: assert property (@(posedge dpath_clk) disable iff (ctrl_rst)
    resp_vld && exp_any |-> resp_rd == exp_rd && resp_data == exp_data)
  else begin
    errors++;
    $display("Error at %0t: response rd=%0d data=%h expected rd=%0d data=%h",
             $time, resp_rd, resp_data, exp_rd, exp_data);
  end

  resp_hold_chk: assert property (@(posedge dpath_clk) disable iff (ctrl_rst)
    $past(resp_vld && !resp_rdy) |-> resp_vld && $stable(resp_rd) && $stable(resp_data))
  else begin
    errors++;
    $display("Error at %0t: stalled response changed", $time);
  end

  busy_rdy_chk: assert property (@(posedge dpath_clk) disable iff (ctrl_rst)
    resp_vld |-> !cmd_rdy)
  else begin
    errors++;
    $display("Error at %0t: cmd_rdy high with a response pending", $time);
  end

  mem_req_chk: assert property (@(posedge dpath_clk) disable iff (ctrl_rst)
    mem_req_vld |-> exp_mem_on && mem_req_cmd == exp_mem_cmd &&
      mem_req_addr == exp_mem_addr &&
      (mem_req_cmd == accel_pkg::mem_cmd_load || mem_req_data == exp_mem_wdata))
  else begin
    errors++;
    $display("Error at %0t: memory request cmd=%0d addr=%h data=%h expected cmd=%0d addr=%h",
             $time, mem_req_cmd, mem_req_addr, mem_req_data, exp_mem_cmd, exp_mem_addr);
  end

  mem_hold_chk: assert property (@(posedge dpath_clk) disable iff (ctrl_rst)
    $past(mem_req_vld && !mem_req_rdy) |-> mem_req_vld && $stable(mem_req_cmd) &&
      $stable(mem_req_addr) && $stable(mem_req_data))
  else begin
    errors++;
    $display("Error at %0t: stalled memory request changed", $time);
  end

  drop_chk: assert property (@(posedge dpath_clk) disable iff (ctrl_rst)
    $past(bad_take) |-> cmd_rdy && !mem_req_vld && !resp_vld)
  else begin
    errors++;
    $display("Error at %0t: unknown function code was not dropped", $time);
  end

  function automatic logic [63:0] rand64();
    return {$urandom, $urandom};
  endfunction

  // Waits for an idle DUT, predicts the outcome, then drives one command
  task automatic send_cmd(input logic [accel_pkg::funct_w-1:0] funct,
                          input logic [accel_pkg::reg_w-1:0]   rd,
                          input logic [accel_pkg::data_w-1:0]  rs1,
                          input logic [accel_pkg::data_w-1:0]  rs2);
    logic [accel_pkg::addr_w-1:0] addr;
    logic [accel_pkg::data_w-1:0] result;
    logic [accel_pkg::data_w-1:0] junk;
    int n;
    if (timeouts != 0) begin
      return;
    end
    n = 0;
    while (!cmd_rdy && n < wait_limit) begin
      @(negedge dpath_clk);
      n++;
    end
    if (!cmd_rdy) begin
      $display("Timeout: cmd_rdy stayed low for %0d cycles", wait_limit);
      timeouts++;
      return;
    end
    addr          = rs2[accel_pkg::addr_w-1:0];
    exp_mem_on    = 1'b0;
    exp_mem_addr  = addr;
    exp_mem_wdata = rs1;
    result        = rs1 + rs2;
    if (funct == accel_pkg::funct_store) begin
      ref_mem[addr] = rs1;
      exp_mem_on    = 1'b1;
      exp_mem_cmd   = accel_pkg::mem_cmd_store;
      result        = rs1;
    end else if (funct == accel_pkg::funct_load) begin
      exp_mem_on  = 1'b1;
      exp_mem_cmd = accel_pkg::mem_cmd_load;
      result      = ref_mem.exists(addr) ? ref_mem[addr] : 64'h0;
    end
    if (funct == accel_pkg::funct_store || funct == accel_pkg::funct_load ||
        funct == accel_pkg::funct_add) begin
      exp_q.push_back({rd, result});
    end else begin
      n_dropped++;
    end
    // Unused command bits carry noise
    junk = rand64();
    cmd = {junk, junk, junk[31:0]};
    cmd[accel_pkg::cmd_funct_lsb +: accel_pkg::funct_w] = funct;
    cmd[accel_pkg::cmd_rd_lsb +: accel_pkg::reg_w]      = rd;
    cmd[accel_pkg::cmd_rs1_lsb +: accel_pkg::data_w]    = rs1;
    cmd[accel_pkg::cmd_rs2_lsb +: accel_pkg::data_w]    = rs2;
    cmd_vld = 1'b1;
    n_sent++;
    @(negedge dpath_clk);
    cmd_vld = 1'b0;
  endtask

  task automatic run_directed();
    logic [accel_pkg::data_w-1:0] wdata;
    wdata = rand64();
    send_cmd(accel_pkg::funct_add, 5'd7, 64'hffff_ffff_ffff_fff0, 64'h20);
    send_cmd(accel_pkg::funct_add, 5'd31, rand64(), rand64());
    send_cmd(accel_pkg::funct_store, 5'd3, wdata, {24'hc3c3c3, addr_base});
    send_cmd(accel_pkg::funct_load, 5'd4, rand64(), {24'h0, addr_base});
    send_cmd(accel_pkg::funct_load, 5'd5, rand64(), {24'h0, addr_base ^ 40'h80});
    send_cmd(7'h55, 5'd9, rand64(), rand64());
    send_cmd(7'd3, 5'd11, rand64(), rand64());
    send_cmd(accel_pkg::funct_add, 5'd10, rand64(), rand64());
  endtask

  task automatic run_random();
    logic [31:0]                  r;
    logic [accel_pkg::data_w-1:0] rs2;
    logic [accel_pkg::funct_w-1:0] funct;
    for (int i = 0; i < num_random; i++) begin
      if (timeouts != 0) begin
        return;
      end
      r   = $urandom;
      rs2 = rand64();
      // Small address window so loads hit earlier stores
      rs2[accel_pkg::addr_w-1:0] = {addr_base[39:7], r[11:8], 3'b000};
      if (r[3:0] < 4'd5) begin
        funct = accel_pkg::funct_store;
      end else if (r[3:0] < 4'd10) begin
        funct = accel_pkg::funct_load;
      end else if (r[3:0] < 4'd14) begin
        funct = accel_pkg::funct_add;
      end else begin
        funct = {1'b1, r[29:24]};
      end
      send_cmd(funct, r[20:16], rand64(), rs2);
      if (r[31]) begin
        @(negedge dpath_clk);
      end
    end
  endtask

  task automatic wait_drain();
    int n;
    if (timeouts != 0) begin
      return;
    end
    n = 0;
    while ((exp_q.size() != 0 || !cmd_rdy) && n < wait_limit) begin
      @(negedge dpath_clk);
      n++;
    end
    if (exp_q.size() != 0 || !cmd_rdy) begin
      $display("Timeout: %0d expected responses never arrived", exp_q.size());
      timeouts++;
    end
  endtask

  initial begin
    void'($urandom(32'ha31b8419));
    ctrl_rst      = 1'b1;
    cmd           = '0;
    cmd_vld       = 1'b0;
    exp_mem_on    = 1'b0;
    exp_mem_cmd   = accel_pkg::mem_cmd_load;
    exp_mem_addr  = '0;
    exp_mem_wdata = '0;
    timeouts      = 0;
    n_sent        = 0;
    n_resp        = 0;
    n_dropped     = 0;
    seed_word     = rand64();
    addr_base     = seed_word[accel_pkg::addr_w-1:0];
    repeat (3) @(posedge dpath_clk);
    @(negedge dpath_clk);
    ctrl_rst = 1'b0;
    run_directed();
    run_random();
    wait_drain();
    // Idle tail so a stray response still trips a check
    repeat (4) @(negedge dpath_clk);
    $display("Summary: %0d commands, %0d responses, %0d dropped, %0d errors, %0d timeouts",
             n_sent, n_resp, n_dropped, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- flist.f
accel_pkg.sv
accel_ctrl.sv
accel_dpath.sv
accel_top.sv
tb_mem_model.sv
tb_accel_top.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -j 0 \
  --top-module tb_accel_top \
  -Mdir obj_dir \
  -o sim_accel \
  -f flist.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

if [ ! -x ./obj_dir/sim_accel ]; then
  echo "Simulation executable was not produced"
  exit 1
fi

out=$(./obj_dir/sim_accel 2>&1)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only when the testbench printed its pass line
if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
  exit 0
fi

echo "Pass line not found in simulation output"
exit 1
